// ==== source/revo_settings.svh ====
`ifndef REVO_SETTINGS_SVH
`define REVO_SETTINGS_SVH

// clock127 cycles in one beam orbit
`define ORBIT_CLOCKS 1280

`define FRAME_ORBITS 9 // orbits per frame

`define PRESCALE_LOG2_BITS 4 // exponent up to 15

`define TRIGGER_COUNT_BITS 16

`endif

// ==== source/orbit_pkg.sv ====
`include "revo_settings.svh"

package orbit_pkg;

	// 0 to 1279
	typedef logic [$clog2(`ORBIT_CLOCKS)-1:0] orbit_pos_t;

	// 0 to 8
	typedef logic [$clog2(`FRAME_ORBITS)-1:0] frame_index_t;

	typedef enum logic {
		sync_searching,
		sync_locked
	} sync_state_t;

endpackage

// ==== source/trigger_pkg.sv ====
`include "revo_settings.svh"

package trigger_pkg;

	typedef enum logic [2:0] {
		op_marker_a,
		op_marker_b,
		op_marker_c,
		op_marker_d,
		op_prescale,
		op_enable
	} config_op_t;

	typedef struct packed {
		logic [`FRAME_ORBITS-1:0] frame_mask; // bit k arms orbit k of the frame
		orbit_pkg::orbit_pos_t position;
	} bunch_marker_t;

	// a has the highest priority
	typedef enum logic [1:0] {
		marker_a,
		marker_b,
		marker_c,
		marker_d
	} marker_id_t;

endpackage

// ==== source/orbit_if.sv ====
`timescale 1ns/1ps

interface orbit_if;
	import orbit_pkg::*;

	orbit_pos_t position;
	logic orbit_start; // first cycle of an orbit
	frame_index_t frame_index;
	logic locked;

	modport decoder (
		output position, orbit_start, frame_index, locked
	);

	modport sink (
		input position, orbit_start, frame_index, locked
	);

endinterface

// ==== source/config_if.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

interface config_if;
	import trigger_pkg::*;

	bunch_marker_t markers [4]; // indexed by marker id
	logic [`PRESCALE_LOG2_BITS-1:0] prescale_log2;
	logic enable;

	modport source (
		output markers, prescale_log2, enable
	);

	modport sink (
		input markers, prescale_log2, enable
	);

endinterface

// ==== source/revo_decoder.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_decoder (
	input logic clock127,
	input logic reset,
	input logic revo,
	orbit_if.decoder orbit
);
	import orbit_pkg::*;

	orbit_pos_t position;
	frame_index_t frame_index;
	frame_index_t frame_index_next;
	sync_state_t state;
	logic orbit_start;
	logic orbit_end;
	logic new_orbit;

	assign orbit_end = (position == orbit_pos_t'(`ORBIT_CLOCKS - 1));
	assign new_orbit = revo || orbit_end; // revo wins over the free-running wrap

	assign frame_index_next = (frame_index == frame_index_t'(`FRAME_ORBITS - 1)) ?
		'0 : frame_index + 1'b1;

	always_ff @(posedge clock127) begin
		if (reset) begin
			position <= '0;
			frame_index <= '0;
			orbit_start <= 1'b0;
		end else begin
			orbit_start <= new_orbit;
			if (new_orbit) begin
				position <= '0;
				frame_index <= frame_index_next; // index is valid with orbit_start
			end else begin
				position <= position + 1'b1;
			end
		end
	end

	// a revo off the expected slot is a phase error
	always_ff @(posedge clock127) begin
		if (reset) begin
			state <= sync_searching;
		end else if (revo) begin
			case (state)
				sync_searching: state <= sync_locked;
				sync_locked: begin
					if (!orbit_end) begin
						state <= sync_searching; // realigned so lock drops
					end
				end
			endcase
		end
	end

	assign orbit.position = position;
	assign orbit.orbit_start = orbit_start;
	assign orbit.frame_index = frame_index;
	assign orbit.locked = (state == sync_locked);

endmodule

// ==== source/trigger_config.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module trigger_config (
	input logic clock127,
	input logic reset,
	input logic config_strobe,
	input trigger_pkg::config_op_t config_op,
	input logic [24:0] config_data,
	config_if.source cfg
);
	import trigger_pkg::*;

	bunch_marker_t data_marker;

	// legacy 25-bit marker register layout
	assign data_marker.position = config_data[12:2];
	assign data_marker.frame_mask = config_data[24:16];

	always_ff @(posedge clock127) begin
		if (reset) begin
			for (int i = 0; i < 4; i++) begin
				cfg.markers[i] <= '0;
			end
			cfg.prescale_log2 <= '0;
			cfg.enable <= 1'b0;
		end else if (config_strobe) begin
			case (config_op)
				op_marker_a: cfg.markers[marker_a] <= data_marker;
				op_marker_b: cfg.markers[marker_b] <= data_marker;
				op_marker_c: cfg.markers[marker_c] <= data_marker;
				op_marker_d: cfg.markers[marker_d] <= data_marker;
				op_prescale: cfg.prescale_log2 <= config_data[`PRESCALE_LOG2_BITS-1:0];
				op_enable: cfg.enable <= config_data[0];
				default: ; // unused opcodes ignored
			endcase
		end
	end

endmodule

// ==== source/bunch_marker_matcher.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module bunch_marker_matcher (
	input logic clock127,
	input logic reset,
	orbit_if.sink orbit,
	config_if.sink cfg,
	output logic hit,
	output trigger_pkg::marker_id_t hit_marker
);
	import trigger_pkg::*;

	localparam int PRESCALE_COUNT_BITS = 1 << `PRESCALE_LOG2_BITS; // holds 2^15

	bunch_marker_t snap [4];
	logic armed;
	logic frame_boundary;
	logic [PRESCALE_COUNT_BITS-1:0] frame_count;
	logic [PRESCALE_COUNT_BITS-1:0] frame_limit;
	logic match;
	marker_id_t match_id;

	assign frame_boundary = orbit.orbit_start && (orbit.frame_index == '0);
	assign frame_limit = {{(PRESCALE_COUNT_BITS-1){1'b0}}, 1'b1} << cfg.prescale_log2;

	// configuration only changes between frames
	always_ff @(posedge clock127) begin
		if (frame_boundary) begin
			snap <= cfg.markers;
		end
	end

	always_ff @(posedge clock127) begin
		if (reset) begin
			armed <= 1'b0;
			frame_count <= {{(PRESCALE_COUNT_BITS-1){1'b0}}, 1'b1};
		end else if (frame_boundary) begin
			armed <= 1'b0;
			if (cfg.enable && orbit.locked) begin
				if (frame_count < frame_limit) begin
					frame_count <= frame_count + 1'b1;
				end else begin
					armed <= 1'b1; // one frame in 2^N
					frame_count <= {{(PRESCALE_COUNT_BITS-1){1'b0}}, 1'b1};
				end
			end
		end
	end

	// walk d up to a so the highest-priority position match decides
	always_comb begin
		match = 1'b0;
		match_id = marker_a;
		for (int i = 3; i >= 0; i--) begin
			if (snap[i].position == orbit.position) begin
				match = snap[i].frame_mask[orbit.frame_index];
				match_id = marker_id_t'(i);
			end
		end
	end

	always_ff @(posedge clock127) begin
		if (reset) begin
			hit <= 1'b0;
		end else begin
			hit <= armed && match;
		end
	end

	always_ff @(posedge clock127) begin
		hit_marker <= match_id;
	end

endmodule

// ==== source/trigger_output.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module trigger_output (
	input logic clock127,
	input logic reset,
	orbit_if.sink orbit,
	input logic hit,
	input trigger_pkg::marker_id_t hit_marker,
	output logic frame,
	output logic frame9,
	output logic trigger,
	output trigger_pkg::marker_id_t trigger_marker,
	output logic [`TRIGGER_COUNT_BITS-1:0] trigger_count
);

	always_ff @(posedge clock127) begin
		if (reset) begin
			frame <= 1'b0;
			frame9 <= 1'b0;
			trigger <= 1'b0;
			trigger_count <= '0;
		end else begin
			frame <= orbit.orbit_start;
			frame9 <= orbit.orbit_start && (orbit.frame_index == '0); // first orbit of frame
			trigger <= hit;
			if (hit) begin
				trigger_count <= trigger_count + 1'b1; // wraps
			end
		end
	end

	always_ff @(posedge clock127) begin
		trigger_marker <= hit_marker;
	end

endmodule

// ==== source/revo_trigger_top.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_trigger_top (
	input logic clock127,
	input logic reset,
	input logic revo, // already decoded single-cycle strobe
	input logic config_strobe,
	input trigger_pkg::config_op_t config_op,
	input logic [24:0] config_data,
	output logic frame,
	output logic frame9,
	output logic trigger,
	output trigger_pkg::marker_id_t trigger_marker,
	output logic [`TRIGGER_COUNT_BITS-1:0] trigger_count,
	output logic locked
);

	orbit_if orbit_bus ();
	config_if cfg_bus ();

	revo_decoder u_revo_decoder (
		.clock127 (clock127),
		.reset (reset),
		.revo (revo),
		.orbit (orbit_bus.decoder)
	);

	trigger_config u_trigger_config (
		.clock127 (clock127),
		.reset (reset),
		.config_strobe (config_strobe),
		.config_op (config_op),
		.config_data (config_data),
		.cfg (cfg_bus.source)
	);

	trigger_pkg::marker_id_t hit_marker;
	logic hit;

	bunch_marker_matcher u_bunch_marker_matcher (
		.clock127 (clock127),
		.reset (reset),
		.orbit (orbit_bus.sink),
		.cfg (cfg_bus.sink),
		.hit (hit),
		.hit_marker (hit_marker)
	);

	trigger_output u_trigger_output (
		.clock127 (clock127),
		.reset (reset),
		.orbit (orbit_bus.sink),
		.hit (hit),
		.hit_marker (hit_marker),
		.frame (frame),
		.frame9 (frame9),
		.trigger (trigger),
		.trigger_marker (trigger_marker),
		.trigger_count (trigger_count)
	);

	assign locked = orbit_bus.locked;

endmodule

// ==== dv/revo_trigger_checks.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_trigger_checks (
	input logic clock127,
	input logic reset,
	input logic revo,
	input logic frame,
	input logic frame9,
	input logic trigger,
	input trigger_pkg::marker_id_t trigger_marker,
	input logic [`TRIGGER_COUNT_BITS-1:0] trigger_count,
	input logic locked,
	input logic exp_frame,
	input logic exp_frame9,
	input logic exp_trigger,
	input logic [1:0] exp_marker,
	input logic [`TRIGGER_COUNT_BITS-1:0] exp_count,
	input logic exp_locked,
	output logic check_error
);

	initial check_error = 1'b0;

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		$display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
		check_error = 1'b1;
	endtask

	task automatic report_broken_rule(input string what);
		$display("rule broken: %s", what);
		check_error = 1'b1;
	endtask

	// outputs against the reference model
	assert property (@(posedge clock127) disable iff (reset) frame == exp_frame)
		else report_mismatch("frame", $sampled(frame), $sampled(exp_frame));
	assert property (@(posedge clock127) disable iff (reset) frame9 == exp_frame9)
		else report_mismatch("frame9", $sampled(frame9), $sampled(exp_frame9));
	assert property (@(posedge clock127) disable iff (reset) trigger == exp_trigger)
		else report_mismatch("trigger", $sampled(trigger), $sampled(exp_trigger));
	assert property (@(posedge clock127) disable iff (reset)
		trigger |-> trigger_marker == exp_marker)
		else report_mismatch("trigger_marker", $sampled(trigger_marker), $sampled(exp_marker));
	assert property (@(posedge clock127) disable iff (reset) trigger_count == exp_count)
		else report_mismatch("trigger_count", $sampled(trigger_count), $sampled(exp_count));
	assert property (@(posedge clock127) disable iff (reset) locked == exp_locked)
		else report_mismatch("locked", $sampled(locked), $sampled(exp_locked));

	// fixed timing rules
	assert property (@(posedge clock127) disable iff (reset) frame9 |-> frame)
		else report_broken_rule("frame9 pulsed without a frame pulse");
	assert property (@(posedge clock127) disable iff (reset) $past(revo, 2) |-> frame)
		else report_broken_rule("frame did not pulse one cycle after the revo restart");
	assert property (@(posedge clock127) disable iff (reset)
		$past(revo) && !$past(locked) |-> locked)
		else report_broken_rule("a revo while searching did not raise locked");

endmodule

// ==== dv/revo_trigger_tb.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_trigger_tb;
	import trigger_pkg::*;

	localparam int FRAME_CYCLES = `FRAME_ORBITS * `ORBIT_CLOCKS;
	localparam int TEST_FRAMES = 16; // frame9 waits plus the lock phase
	localparam int CYCLE_LIMIT = (TEST_FRAMES + 3) * FRAME_CYCLES;

	logic clock127;
	logic reset;
	logic revo;
	logic config_strobe;
	config_op_t config_op;
	logic [24:0] config_data;
	logic frame;
	logic frame9;
	logic trigger;
	marker_id_t trigger_marker;
	logic [`TRIGGER_COUNT_BITS-1:0] trigger_count;
	logic locked;
	logic check_error;
	int cycle_count = 0;

	logic [10:0] m_pos;
	logic [3:0] m_findex;
	logic m_start;
	logic [8:0] c_mask [4];
	logic [10:0] c_pos [4];
	logic [3:0] c_prescale;
	logic c_enable;
	logic [8:0] s_mask [4]; // frame snapshot
	logic [10:0] s_pos [4];
	logic m_armed;
	int frames_seen;
	logic m_hit;
	logic [1:0] m_hit_id;
	logic exp_frame;
	logic exp_frame9;
	logic exp_trigger;
	logic [1:0] exp_marker;
	logic [`TRIGGER_COUNT_BITS-1:0] exp_count;
	logic exp_locked;

	revo_trigger_top u_revo_trigger_top (.*);
	revo_trigger_checks u_revo_trigger_checks (.*);

	initial begin
		clock127 = 1'b0;
		forever #10 clock127 = ~clock127;
	end

	always @(posedge clock127) begin : reference_model
		logic found;
		logic hit_now;
		logic [1:0] hit_id;
		found = 1'b0;
		hit_now = 1'b0;
		hit_id = 2'd0;
		for (int i = 0; i < 4; i++) begin
			if (!found && s_pos[i] == m_pos) begin // first position match decides
				found = 1'b1;
				hit_now = m_armed && s_mask[i][m_findex];
				hit_id = 2'(i);
			end
		end
		if (reset) begin
			m_pos <= '0;
			m_findex <= '0;
			m_start <= 1'b0;
			exp_locked <= 1'b0;
			for (int i = 0; i < 4; i++) begin
				c_mask[i] <= '0;
				c_pos[i] <= '0;
				s_mask[i] <= '0;
				s_pos[i] <= '0;
			end
			c_prescale <= '0;
			c_enable <= 1'b0;
			m_armed <= 1'b0;
			frames_seen <= 0;
			m_hit <= 1'b0;
			exp_frame <= 1'b0;
			exp_frame9 <= 1'b0;
			exp_trigger <= 1'b0;
			exp_count <= '0;
		end else begin
			m_start <= revo || m_pos == 11'd1279;
			if (revo || m_pos == 11'd1279) begin
				m_pos <= '0;
				m_findex <= (m_findex == 4'd8) ? 4'd0 : m_findex + 4'd1;
			end else begin
				m_pos <= m_pos + 11'd1;
			end
			if (revo) begin
				exp_locked <= !exp_locked || m_pos == 11'd1279; // off-slot revo unlocks
			end
			if (config_strobe) begin
				case (config_op)
					op_prescale: c_prescale <= config_data[3:0];
					op_enable: c_enable <= config_data[0];
					op_marker_a, op_marker_b, op_marker_c, op_marker_d: begin
						c_pos[config_op[1:0]] <= config_data[12:2];
						c_mask[config_op[1:0]] <= config_data[24:16];
					end
					default: ;
				endcase
			end
			if (m_start && m_findex == 4'd0) begin
				s_mask <= c_mask;
				s_pos <= c_pos;
				m_armed <= 1'b0;
				if (c_enable && exp_locked) begin
					if (frames_seen + 1 >= (1 << c_prescale)) begin
						m_armed <= 1'b1;
						frames_seen <= 0;
					end else begin
						frames_seen <= frames_seen + 1;
					end
				end
			end
			m_hit <= hit_now;
			m_hit_id <= hit_id;
			exp_trigger <= m_hit;
			exp_marker <= m_hit_id;
			exp_count <= exp_count + `TRIGGER_COUNT_BITS'(m_hit);
			exp_frame <= m_start;
			exp_frame9 <= m_start && m_findex == 4'd0;
		end
	end

	always @(posedge clock127) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$fatal(1, "timeout");
		end
	end

	always @(posedge check_error) begin
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	end

	function automatic logic [24:0] marker_word(input logic [8:0] mask, input logic [10:0] pos);
		return {mask, 3'b000, pos, 2'b00};
	endfunction

	task automatic write_config(input config_op_t op, input logic [24:0] data);
		config_strobe <= 1'b1;
		config_op <= op;
		config_data <= data;
		@(posedge clock127);
		config_strobe <= 1'b0;
	endtask

	task automatic wait_frame9(input int count);
		repeat (count) begin
			@(posedge clock127);
			while (!frame9) @(posedge clock127);
		end
	endtask

	// revo lands one position after at_pos
	task automatic send_revo(input int at_pos);
		while (m_pos != 11'(at_pos)) @(posedge clock127);
		revo <= 1'b1;
		@(posedge clock127);
		revo <= 1'b0;
	endtask

	task automatic load_random_markers();
		for (int i = 0; i < 4; i++) begin
			write_config(config_op_t'(i), marker_word(9'($urandom_range(511, 1)),
				11'($urandom_range(1279, 0))));
		end
	endtask

	initial begin
		logic [10:0] shared_pos;
		logic [8:0] mask_a;
		void'($urandom(32'h4e542384));
		reset = 1'b1;
		revo = 1'b0;
		config_strobe = 1'b0;
		config_op = op_marker_a;
		config_data = '0;
		repeat (3) @(posedge clock127);
		reset <= 1'b0;
		wait_frame9(2); // free running and unlocked
		send_revo(400);
		send_revo(1278); // lands on the expected slot
		send_revo(700); // phase error
		send_revo(1278);
		send_revo(1278);
		write_config(op_enable, 25'd1);
		load_random_markers();
		wait_frame9(3);
		shared_pos = 11'($urandom_range(1279, 0));
		mask_a = 9'($urandom_range(510, 1));
		write_config(op_marker_a, marker_word(mask_a, shared_pos));
		write_config(op_marker_b, marker_word(~mask_a, shared_pos)); // b only where a is off
		wait_frame9(2);
		write_config(op_prescale, 25'd2);
		load_random_markers();
		wait_frame9(6);
		write_config(op_enable, 25'd0);
		wait_frame9(2);
		if (check_error) begin
			$display("Something failed");
			$fatal(1, "errors were reported");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// ==== revo_trigger_top.f ====
+incdir+source
source/orbit_pkg.sv
source/trigger_pkg.sv
source/orbit_if.sv
source/config_if.sv
source/revo_decoder.sv
source/trigger_config.sv
source/bunch_marker_matcher.sv
source/trigger_output.sv
source/revo_trigger_top.sv
dv/revo_trigger_checks.sv
dv/revo_trigger_tb.sv
